// ==== all.f ====
tlb_pkg.sv
tlb_req_if.sv
tlb_walk_if.sv
tlb_req_decode.sv
tlb_core.sv
page_perm_check.sv
tlb_top.sv
tb_tlb.sv

// ==== page_perm_check.sv ====
`timescale 1ns/1ns
// permission stage that builds the physical address and raises Sv32 page faults
module page_perm_check (
    tlb_walk_if.check     chk,
    input  tlb_pkg::prv_t prv,
    input  logic          sum,
    output logic [31:0]   paddr,
    output logic          fault_load,
    output logic          fault_store,
    output logic          fault_fetch
);

    tlb_pkg::pte_perms_t p;
    logic                is_store;
    logic                no_access;
    logic                fault;

    assign p        = chk.pte.perms;
    assign is_store = (chk.access == tlb_pkg::STORE);

    // R/W/X needed by the access kind
    always_comb begin
        case (chk.access)
            tlb_pkg::LOAD:  no_access = !p.readable;
            tlb_pkg::STORE: no_access = !p.writable;
            tlb_pkg::FETCH: no_access = !p.executable;
            default:        no_access = 1'b1;
        endcase
    end

    assign fault = chk.resp && (chk.walk_error
        || !p.valid || (p.writable && !p.readable)   // reserved encoding
        || no_access
        || !p.accessed
        || (is_store && !p.dirty)
        || (p.user && (prv == tlb_pkg::SUPERVISOR) && !sum)
        || (!p.user && (prv == tlb_pkg::USER)));

    assign paddr = chk.resp
        ? {chk.pte.ppn[31-tlb_pkg::PAGE_OFFSET_BITS:0],
           chk.vaddr[tlb_pkg::PAGE_OFFSET_BITS-1:0]}
        : '0;

    assign fault_load  = fault && (chk.access == tlb_pkg::LOAD);
    assign fault_store = fault && is_store;
    assign fault_fetch = fault && (chk.access == tlb_pkg::FETCH);

    // a response with no access kind would hide its fault
    assert property (@(posedge chk.CLK)
        $onehot0({fault_load, fault_store, fault_fetch})
        && (!chk.resp || (chk.access != tlb_pkg::NONE)))
        else $error("more than one fault, or a response without an access kind");

endmodule

// ==== run.sh ====
#!/bin/sh
# build the TLB testbench with Verilator, run it and grep the log for the result
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -j 0 --top-module tb_tlb -o tb_tlb_sim -f all.f
./obj_dir/tb_tlb_sim > sim.log 2>&1 || true
cat sim.log
if grep -qx "TEST RESULT: PASS" sim.log; then
    exit 0
fi
exit 1

// ==== tb_tlb.sv ====
`timescale 1ns/1ns
// testbench for the Sv32 data TLB, random traffic against a walker model and a reference TLB
module tb_tlb;

    localparam int POOL    = 16;   // two pages per set, sets 0..7
    localparam int TIMEOUT = 200;  // cycles per wait

    logic          CLK, nRST, ren, wen, fetch, sum, fence;
    logic          busy, fault_load, fault_store, fault_fetch, fence_done;
    logic          walk_ren, walk_busy, walk_error;
    logic [31:0]   vaddr, paddr, fence_va, walk_rdata;
    logic [8:0]    asid, fence_asid;
    logic [19:0]   walk_addr;
    tlb_pkg::prv_t prv;

    tlb_pkg::pte_t pte_table [POOL];  // walker memory, one leaf PTE per pool page
    logic          m_valid [16][2] = '{default: 1'b0};
    logic [19:0]   m_vpn   [16][2];
    logic [8:0]    m_asid  [16][2];
    tlb_pkg::pte_t m_pte   [16][2];
    logic          m_ptr   [16] = '{default: 1'b0};  // next victim per set
    int            checks = 0;
    int            mismatches = 0;
    int            others = 0;
    int            fences = 0;
    int            done_pulses = 0;

    tlb_top dut_i (.*);

    initial begin
        CLK = 1'b0;
        forever #4 CLK = ~CLK;
    end

    always @(negedge CLK)
        if (fence_done)
            done_pulses++;

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            $display("MISMATCH %s got %h expected %h", name, got, exp);
            mismatches++;
        end
    endtask

    function automatic logic [19:0] pool_vpn(input int idx);
        return {4'hA, 12'(idx / 8), 4'(idx % 8)};
    endfunction

    // Sv32 leaf permission rule
    function automatic logic fault_expected(input tlb_pkg::pte_t pte, input tlb_pkg::access_t kind,
                                            input tlb_pkg::prv_t pv, input logic s);
        tlb_pkg::pte_perms_t f;
        logic                allowed;
        f = pte.perms;
        case (kind)
            tlb_pkg::LOAD:  allowed = f.readable;
            tlb_pkg::STORE: allowed = f.writable && f.dirty;
            default:        allowed = f.executable;
        endcase
        if (pv == tlb_pkg::SUPERVISOR)
            allowed = allowed && !(f.user && !s);
        else
            allowed = allowed && f.user;
        return !allowed || !f.valid || !f.accessed || (f.writable && !f.readable);
    endfunction

    task automatic refill_table();
        logic [7:0] flags;
        for (int i = 0; i < POOL; i++) begin
            flags = 8'($urandom);
            if ($urandom_range(0, 3) != 0)
                flags = flags | 8'hC3;  // mostly valid, readable, accessed, dirty
            pte_table[i] = {22'($urandom), 2'b00, flags};
        end
    endtask

    // one held request, with the walker answering while walk_ren is up
    task automatic access_page(input int idx, input logic long_walks);
        tlb_pkg::access_t kind;
        tlb_pkg::pte_t    exp_pte;
        logic [31:0]      va;
        logic [3:0]       set;
        logic             walked;
        logic             err;
        logic             flt;
        int               way;
        int               lat;
        int               n;
        @(negedge CLK);
        kind  = tlb_pkg::access_t'(2'($urandom_range(1, 3)));
        va    = {pool_vpn(idx), 12'($urandom)};
        set   = va[15:12];
        asid  = 9'($urandom_range(1, 2));
        prv   = tlb_pkg::prv_t'(1'($urandom_range(0, 1)));
        sum   = 1'($urandom_range(0, 1));
        ren   = (kind == tlb_pkg::LOAD);
        wen   = (kind == tlb_pkg::STORE);
        fetch = (kind == tlb_pkg::FETCH);
        vaddr = va;
        lat   = long_walks ? $urandom_range(8, 40) : $urandom_range(0, 3);
        err   = ($urandom_range(0, 7) == 0);
        way   = -1;
        for (int w = 0; w < 2; w++)
            if (m_valid[set][w] && m_vpn[set][w] == va[31:12] && m_asid[set][w] == asid)
                way = w;
        walked = 1'b0;
        n      = 0;
        forever begin
            if (walk_ren) begin
                walked     = 1'b1;
                check_value("walk_addr", 32'(walk_addr), 32'(va[31:12]));
                walk_busy  = (lat > 0);
                walk_error = err && (lat == 0);
                walk_rdata = pte_table[idx];
                if (lat > 0)
                    lat--;
            end
            #1;
            if (walk_ren && walk_busy)
                check_value("busy", 32'(busy), 32'd1);  // held off by the walker
            if (!busy || n == TIMEOUT)
                break;
            n++;
            @(negedge CLK);
        end
        if (busy) begin
            $display("access to %h timed out with busy still high", va);
            others++;
        end else begin
            check_value("walk_ren", 32'(walked), 32'(way < 0));
            exp_pte = (way >= 0) ? m_pte[set][way] : pte_table[idx];
            flt = (err && way < 0) || fault_expected(exp_pte, kind, prv, sum);
            check_value("{fault_load,fault_store,fault_fetch}",
                32'({fault_load, fault_store, fault_fetch}),
                32'({flt && kind == tlb_pkg::LOAD, flt && kind == tlb_pkg::STORE,
                     flt && kind == tlb_pkg::FETCH}));
            if (!flt)
                check_value("paddr", paddr, {exp_pte.ppn[19:0], va[11:0]});
            if (way < 0 && !err) begin  // mirror the fill into the round-robin victim
                m_valid[set][m_ptr[set]] = 1'b1;
                m_vpn[set][m_ptr[set]]   = va[31:12];
                m_asid[set][m_ptr[set]]  = asid;
                m_pte[set][m_ptr[set]]   = pte_table[idx];
                m_ptr[set]               = !m_ptr[set];
            end
        end
    endtask

    task automatic issue_fence(input logic [31:0] va, input logic [8:0] fa);
        int n;
        @(negedge CLK);
        {ren, wen, fetch} = 3'b000;
        fence      = 1'b1;
        fence_va   = va;
        fence_asid = fa;
        fences++;
        @(negedge CLK);
        fence = 1'b0;
        n     = 0;
        while (!fence_done && n < TIMEOUT) begin
            @(negedge CLK);
            n++;
        end
        if (!fence_done) begin
            $display("fence with va %h asid %h never signalled done", va, fa);
            others++;
        end
        // zero va or zero asid means all, globals survive an asid match
        for (int s = 0; s < 16; s++)
            for (int w = 0; w < 2; w++)
                if (m_valid[s][w] && (va == '0 || m_vpn[s][w] == va[31:12])
                    && (fa == '0 || (m_asid[s][w] == fa && !m_pte[s][w].perms.global_page)))
                    m_valid[s][w] = 1'b0;
    endtask

    initial begin
        void'($urandom(64018));
        nRST = 1'b0;
        {ren, wen, fetch, sum, fence} = 5'b00000;
        {vaddr, fence_va, walk_rdata} = '0;
        asid       = 9'd1;
        fence_asid = '0;
        prv        = tlb_pkg::SUPERVISOR;
        walk_busy  = 1'b1;
        walk_error = 1'b0;
        refill_table();
        repeat (16) @(negedge CLK);
        nRST = 1'b1;
        #1;
        check_value("busy", 32'(busy), 32'd1);
        check_value("walk_ren", 32'(walk_ren), 32'd0);
        check_value("fence_done", 32'(fence_done), 32'd0);
        for (int ph = 0; ph < 5; ph++) begin
            if (ph > 0)
                refill_table();  // stale entries keep their old PTEs until fenced
            case (ph)
                1: issue_fence('0, '0);
                2: issue_fence({pool_vpn(3), 12'h5A0}, '0);
                3: issue_fence('0, 9'd1);
                4: issue_fence({pool_vpn(11), 12'h000}, 9'd2);
                default: ;
            endcase
            repeat (60)
                access_page($urandom_range(0, POOL - 1), ph == 4);  // slow walker last
        end
        check_value("fence_done pulses", done_pulses, fences);
        $display("checks %0d, mismatches %0d, other failures %0d", checks, mismatches, others);
        if (mismatches == 0 && others == 0)
            $display("TEST RESULT: PASS");
        else
            $display("TEST RESULT: FAIL");
        $finish;
    end

endmodule

// ==== tlb_core.sv ====
`timescale 1ns/1ns
// two-way TLB array with lookup, walker fill, round-robin replacement and sweeps
module tlb_core (
    input  logic                          CLK,
    input  logic                          nRST,
    tlb_req_if.core                       req,
    tlb_walk_if.core                      chk,
    input  logic [tlb_pkg::ASID_BITS-1:0] asid,
    output logic                          busy,
    output logic                          walk_ren,
    output logic [tlb_pkg::VPN_BITS-1:0]  walk_addr,
    input  logic                          walk_busy,
    input  logic [31:0]                   walk_rdata,
    input  logic                          walk_error
);

    typedef enum logic [1:0] {
        SWEEP_RESET,
        READY,
        WALK,
        SWEEP_FENCE
    } state_t;

    state_t state, next_state;
    logic [tlb_pkg::SET_BITS-1:0] sweep_idx;

    tlb_pkg::tlb_tag_t tags [tlb_pkg::N_SETS][tlb_pkg::N_WAYS];
    tlb_pkg::pte_t     ptes [tlb_pkg::N_SETS][tlb_pkg::N_WAYS];
    logic [$clog2(tlb_pkg::N_WAYS)-1:0] repl_ptr [tlb_pkg::N_SETS];  // next victim per set

    logic [tlb_pkg::VPN_BITS-1:0] vpn;
    logic [tlb_pkg::VPN_BITS-1:0] fence_vpn;
    logic [tlb_pkg::SET_BITS-1:0] set_idx;
    logic [tlb_pkg::TAG_BITS-1:0] vpn_tag;
    logic [tlb_pkg::N_WAYS-1:0]   hit_way;
    logic [tlb_pkg::N_WAYS-1:0]   clr_way;
    logic                         hit;
    logic                         fill;
    logic                         sweeping;
    tlb_pkg::pte_t                hit_pte;

    // va -> [tag 16][set 4][offset 12]
    assign vpn       = req.vaddr[31:tlb_pkg::PAGE_OFFSET_BITS];
    assign set_idx   = vpn[tlb_pkg::SET_BITS-1:0];
    assign vpn_tag   = vpn[tlb_pkg::VPN_BITS-1:tlb_pkg::SET_BITS];
    assign fence_vpn = req.fence_va[31:tlb_pkg::PAGE_OFFSET_BITS];
    assign sweeping  = (state == SWEEP_RESET) || (state == SWEEP_FENCE);

    // compare both ways of the selected set
    always_comb begin
        hit_pte = '0;
        for (int w = 0; w < tlb_pkg::N_WAYS; w++) begin
            hit_way[w] = tags[set_idx][w].valid
                && (tags[set_idx][w].vpn_tag == vpn_tag)
                && (tags[set_idx][w].asid == asid);
            if (hit_way[w])
                hit_pte = ptes[set_idx][w];
        end
    end
    assign hit = |hit_way;

    // which ways of the swept set get invalidated this cycle
    always_comb begin
        for (int w = 0; w < tlb_pkg::N_WAYS; w++) begin
            clr_way[w] = 1'b0;
            if (state == SWEEP_RESET)
                clr_way[w] = 1'b1;
            else if (state == SWEEP_FENCE)
                clr_way[w] = tags[sweep_idx][w].valid
                    && ((req.fence_va == '0)
                        || ({tags[sweep_idx][w].vpn_tag, sweep_idx} == fence_vpn))
                    && ((req.fence_asid == '0)
                        || ((tags[sweep_idx][w].asid == req.fence_asid)
                            && !ptes[sweep_idx][w].perms.global_page));  // globals survive
        end
    end

    always_comb begin
        next_state     = state;
        busy           = 1'b1;
        walk_ren       = 1'b0;
        fill           = 1'b0;
        chk.resp       = 1'b0;
        chk.walk_error = 1'b0;
        req.fence_done = 1'b0;
        case (state)
            SWEEP_RESET: begin
                if (sweep_idx == tlb_pkg::SET_BITS'(tlb_pkg::N_SETS - 1))
                    next_state = READY;
            end
            READY: begin
                if (req.valid) begin
                    if (hit) begin
                        busy     = 1'b0;  // zero-cycle hit
                        chk.resp = 1'b1;
                    end else begin
                        next_state = WALK;
                    end
                end else if (req.fence_pending) begin
                    next_state = SWEEP_FENCE;  // only between requests
                end
            end
            WALK: begin
                walk_ren = 1'b1;
                if (!walk_busy) begin
                    next_state = READY;
                    if (walk_error) begin
                        busy           = 1'b0;
                        chk.resp       = 1'b1;
                        chk.walk_error = 1'b1;
                    end else begin
                        fill = 1'b1;  // held request hits next cycle
                    end
                end
            end
            SWEEP_FENCE: begin
                if (sweep_idx == tlb_pkg::SET_BITS'(tlb_pkg::N_SETS - 1)) begin
                    req.fence_done = 1'b1;
                    next_state     = READY;
                end
            end
            default: next_state = SWEEP_RESET;
        endcase
    end

    assign walk_addr  = vpn;  // pipeline holds vaddr through the walk
    assign chk.pte    = (state == WALK) ? tlb_pkg::pte_t'(walk_rdata) : hit_pte;
    assign chk.access = req.access;
    assign chk.vaddr  = req.vaddr;

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state     <= SWEEP_RESET;
            sweep_idx <= '0;
            for (int s = 0; s < tlb_pkg::N_SETS; s++)
                repl_ptr[s] <= '0;
        end else begin
            state <= next_state;
            if (sweeping)
                sweep_idx <= sweep_idx + 1'b1;  // wraps to 0 at the end of a sweep
            if (fill)
                repl_ptr[set_idx] <= repl_ptr[set_idx] + 1'b1;
        end
    end

    // tag and PTE array writes
    always_ff @(posedge CLK) begin
        for (int w = 0; w < tlb_pkg::N_WAYS; w++) begin
            if (clr_way[w])
                tags[sweep_idx][w].valid <= 1'b0;
        end
        if (fill) begin
            tags[set_idx][repl_ptr[set_idx]] <= '{valid: 1'b1, asid: asid, vpn_tag: vpn_tag};
            ptes[set_idx][repl_ptr[set_idx]] <= walk_rdata;
        end
    end

    assert property (@(posedge CLK) disable iff (!nRST)
        walk_ren |-> (state == WALK) && req.valid)
        else $error("walk_ren outside WALK or without a held request");

    assert property (@(posedge CLK) disable iff (!nRST)
        walk_ren && walk_busy |=> walk_ren && $stable(walk_addr))
        else $error("walker request dropped or changed while busy");

    assert property (@(posedge CLK) disable iff (!nRST)
        (state == READY) |-> $onehot0(hit_way))
        else $error("hit in both ways of set %0d", set_idx);

endmodule

// ==== tlb_pkg.sv ====
// Sv32 data TLB shared sizes, PTE and tag layouts, access and privilege kinds
package tlb_pkg;

    localparam int PAGE_OFFSET_BITS = 12;  // 4 KiB pages
    localparam int VPN_BITS         = 20;
    localparam int PPN_BITS         = 22;
    localparam int N_SETS           = 16;
    localparam int N_WAYS           = 2;
    localparam int SET_BITS         = 4;
    localparam int TAG_BITS         = 16;  // vpn bits above the set index
    localparam int ASID_BITS        = 9;

    // low ten bits of an Sv32 PTE
    typedef struct packed {
        logic [1:0] rsw;          // reserved for software
        logic       dirty;
        logic       accessed;
        logic       global_page;
        logic       user;
        logic       executable;
        logic       writable;
        logic       readable;
        logic       valid;
    } pte_perms_t;

    typedef struct packed {
        logic [PPN_BITS-1:0] ppn;
        pte_perms_t          perms;
    } pte_t;

    // valid + asid + vpn tag, 26 bits
    typedef struct packed {
        logic                 valid;
        logic [ASID_BITS-1:0] asid;
        logic [TAG_BITS-1:0]  vpn_tag;
    } tlb_tag_t;

    typedef enum logic [1:0] {
        NONE,
        LOAD,
        STORE,
        FETCH
    } access_t;

    typedef enum logic {
        USER,
        SUPERVISOR
    } prv_t;

endpackage

// ==== tlb_req_decode.sv ====
`timescale 1ns/1ns
// request decoder, folds the strobes into one access kind and latches fences
module tlb_req_decode (
    input  logic                          CLK,
    input  logic                          nRST,
    input  logic                          ren,
    input  logic                          wen,
    input  logic                          fetch,
    input  logic [31:0]                   vaddr,
    input  logic                          fence,
    input  logic [31:0]                   fence_va,
    input  logic [tlb_pkg::ASID_BITS-1:0] fence_asid,
    tlb_req_if.decode                     req
);

    // store wins over load, load over fetch
    always_comb begin
        if (wen)
            req.access = tlb_pkg::STORE;
        else if (ren)
            req.access = tlb_pkg::LOAD;
        else if (fetch)
            req.access = tlb_pkg::FETCH;
        else
            req.access = tlb_pkg::NONE;
    end

    assign req.valid = ren | wen | fetch;
    assign req.vaddr = vaddr;

    // pulse may land mid-walk, hold it until the core has swept
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST)
            req.fence_pending <= 1'b0;
        else if (fence)
            req.fence_pending <= 1'b1;
        else if (req.fence_done)
            req.fence_pending <= 1'b0;
    end

    always_ff @(posedge CLK) begin
        if (fence) begin
            req.fence_va   <= fence_va;
            req.fence_asid <= fence_asid;
        end
    end

    assert property (@(posedge CLK) disable iff (!nRST) req.fence_done |-> req.fence_pending)
        else $error("fence_done without a pending fence");

endmodule

// ==== tlb_req_if.sv ====
`timescale 1ns/1ns
// request and fence path from the input decoder into the TLB core
interface tlb_req_if;

    logic                          valid;          // held strobe level
    tlb_pkg::access_t              access;
    logic [31:0]                   vaddr;
    logic                          fence_pending;
    logic [31:0]                   fence_va;
    logic [tlb_pkg::ASID_BITS-1:0] fence_asid;
    logic                          fence_done;     // one-cycle pulse from core

    modport decode (
        output valid, access, vaddr, fence_pending, fence_va, fence_asid,
        input  fence_done
    );

    modport core (
        input  valid, access, vaddr, fence_pending, fence_va, fence_asid,
        output fence_done
    );

endinterface

// ==== tlb_top.sv ====
`timescale 1ns/1ns
// Sv32 data TLB top, decoder, core and permission check on plain ports
module tlb_top (
    input  logic                          CLK,
    input  logic                          nRST,
    input  logic                          ren,
    input  logic                          wen,
    input  logic                          fetch,
    input  logic [31:0]                   vaddr,
    output logic                          busy,
    output logic [31:0]                   paddr,
    output logic                          fault_load,
    output logic                          fault_store,
    output logic                          fault_fetch,
    input  logic [tlb_pkg::ASID_BITS-1:0] asid,
    input  tlb_pkg::prv_t                 prv,
    input  logic                          sum,
    input  logic                          fence,
    input  logic [31:0]                   fence_va,
    input  logic [tlb_pkg::ASID_BITS-1:0] fence_asid,
    output logic                          fence_done,
    output logic                          walk_ren,
    output logic [tlb_pkg::VPN_BITS-1:0]  walk_addr,
    input  logic                          walk_busy,
    input  logic [31:0]                   walk_rdata,
    input  logic                          walk_error
);

    tlb_req_if  req_if ();
    tlb_walk_if walk_if (.CLK(CLK));

    assign fence_done = req_if.fence_done;

    tlb_req_decode decode_i (
        .CLK(CLK), .nRST(nRST), .ren(ren), .wen(wen), .fetch(fetch), .vaddr(vaddr),
        .fence(fence), .fence_va(fence_va), .fence_asid(fence_asid), .req(req_if)
    );

    tlb_core core_i (
        .CLK(CLK), .nRST(nRST), .req(req_if), .chk(walk_if), .asid(asid), .busy(busy),
        .walk_ren(walk_ren), .walk_addr(walk_addr), .walk_busy(walk_busy),
        .walk_rdata(walk_rdata), .walk_error(walk_error)
    );

    page_perm_check check_i (
        .chk(walk_if), .prv(prv), .sum(sum), .paddr(paddr),
        .fault_load(fault_load), .fault_store(fault_store), .fault_fetch(fault_fetch)
    );

endmodule

// ==== tlb_walk_if.sv ====
`timescale 1ns/1ns
// hit or filled PTE handed from the TLB core to the permission stage
interface tlb_walk_if (input logic CLK);

    logic             resp;        // result ready this cycle
    tlb_pkg::pte_t    pte;
    logic             walk_error;
    tlb_pkg::access_t access;
    logic [31:0]      vaddr;

    modport core (
        output resp, pte, walk_error, access, vaddr
    );

    // clock only for the checker's assertion
    modport check (
        input CLK, resp, pte, walk_error, access, vaddr
    );

endinterface
